// ==== logic/vecOpPkg.sv ====
`default_nettype none

package vecOpPkg;

    typedef enum logic [2:0] {
        PASS_A,
        PASS_B,
        ALU,
        MUL,
        DIV
    } vfuSel_e;

    typedef enum logic [4:0] {
        ADD, SUB, RSB, EXT,
        ADC, SBC,
        MADC_NC, MADC, MSBC_NB, MSBC,  // carry/borrow out to bit 0
        AND, NAND, ANDN,
        OR, NOR, ORN,
        XOR, XNOR,
        SRL, SRA, SLL,
        SEQ, SNE, SLT, SLE, SGT,
        MIN, MAX,
        MERGE, MOVE
    } aluOp_e;

    typedef enum logic [1:0] {
        MUL_LO,
        MUL_HI,
        MACC  // opC + low product
    } mulOp_e;

    typedef enum logic [1:0] {
        SEW8,
        SEW16,
        SEW32
    } vsew_e;

endpackage

`default_nettype wire

// ==== logic/vecUnitPkg.sv ====
`default_nettype none

package vecUnitPkg;

    localparam int WORD_W      = 32;
    localparam int MUL_LATENCY = 2;   // stall cycles per multiply
    localparam int DIV_CYCLES  = 32;  // stall cycles per divide

    localparam int MUL_CNT_W = $clog2(MUL_LATENCY);
    localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } unitState_e;

endpackage

`default_nettype wire

// ==== logic/vecAlu.sv ====
`default_nettype none

module vecAlu import vecOpPkg::*, vecUnitPkg::*; (
    input  logic [WORD_W-1:0] opA,
    input  logic [WORD_W-1:0] opB,
    input  logic              maskBit,
    input  logic              opUnsigned,
    input  aluOp_e            aluOp,
    input  vsew_e             vsew,
    output logic [WORD_W-1:0] res
);

    logic [WORD_W:0]   wideSum;
    logic [WORD_W:0]   wideDiff;
    logic [WORD_W-1:0] carryIn;
    logic [4:0]        shamt;
    logic              isEq;
    logic              isLt;
    logic              isLe;

    assign carryIn = WORD_W'(maskBit);

    always_comb begin
        wideSum  = {1'b0, opA} + {1'b0, opB};
        wideDiff = {1'b0, opA} - {1'b0, opB};
        if (aluOp == MADC) begin
            wideSum = wideSum + {1'b0, carryIn};
        end
        if (aluOp == MSBC) begin
            wideDiff = wideDiff - {1'b0, carryIn};
        end
    end

    always_comb begin
        case (vsew)
            SEW8:    shamt = {2'b00, opB[2:0]};
            SEW16:   shamt = {1'b0, opB[3:0]};
            default: shamt = opB[4:0];
        endcase
    end

    assign isEq = (opA == opB);
    assign isLt = opUnsigned ? (opA < opB) : ($signed(opA) < $signed(opB));
    assign isLe = isLt || isEq;

    always_comb begin
        res = '0;
        case (aluOp)
            ADD:     res = opA + opB;
            SUB:     res = opA - opB;
            RSB:     res = opB - opA;
            EXT:     res = opA;
            ADC:     res = opA + opB + carryIn;
            SBC:     res = opA - opB - carryIn;
            MADC_NC,
            MADC:    res = WORD_W'(wideSum[WORD_W]);
            MSBC_NB,
            MSBC:    res = WORD_W'(wideDiff[WORD_W]);  // unsigned borrow
            AND:     res = opA & opB;
            NAND:    res = ~(opA & opB);
            ANDN:    res = opA & ~opB;
            OR:      res = opA | opB;
            NOR:     res = ~(opA | opB);
            ORN:     res = opA | ~opB;
            XOR:     res = opA ^ opB;
            XNOR:    res = ~(opA ^ opB);
            SRL:     res = opA >> shamt;
            SRA:     res = $signed(opA) >>> shamt;
            SLL:     res = opA << shamt;
            SEQ:     res = WORD_W'(isEq);
            SNE:     res = WORD_W'(!isEq);
            SLT:     res = WORD_W'(isLt);
            SLE:     res = WORD_W'(isLe);
            SGT:     res = WORD_W'(!isLe);
            MIN:     res = isLt ? opA : opB;
            MAX:     res = isLe ? opB : opA;
            MERGE:   res = maskBit ? opB : opA;
            MOVE:    res = opB;
            default: res = '0;
        endcase
    end

    // no clock at this level, checked on every change
    always_comb begin
        assert (!$isunknown(aluOp)) else $error("vecAlu: aluOp is unknown");
    end

endmodule

`default_nettype wire

// ==== logic/vecMultiplier.sv ====
`default_nettype none

module vecMultiplier import vecOpPkg::*, vecUnitPkg::*; (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              en,
    input  logic              memStall,
    input  logic [WORD_W-1:0] opA,
    input  logic [WORD_W-1:0] opB,
    input  logic [WORD_W-1:0] opC,
    input  mulOp_e            mulOp,
    input  logic              opUnsigned,
    output logic              busy,
    output logic [WORD_W-1:0] res
);

    unitState_e            state;
    logic [MUL_CNT_W-1:0]  cnt;
    logic [2*WORD_W-1:0]   prod;
    logic [2*WORD_W-1:0]   extA;
    logic [2*WORD_W-1:0]   extB;
    logic                  start;

    assign start = en && (state == IDLE);
    assign busy  = start || (state == BUSY);

    assign extA = {{WORD_W{!opUnsigned && opA[WORD_W-1]}}, opA};
    assign extB = {{WORD_W{!opUnsigned && opB[WORD_W-1]}}, opB};

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            cnt   <= '0;
            prod  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (en) begin
                        prod  <= extA * extB;  // low 2W bits are exact
                        cnt   <= '0;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (!memStall) begin  // frozen while memory stalls
                        if (cnt == MUL_CNT_W'(MUL_LATENCY - 2)) begin
                            state <= DONE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;  // DONE
            endcase
        end
    end

    always_comb begin
        case (mulOp)
            MUL_HI:  res = prod[2*WORD_W-1:WORD_W];
            MACC:    res = opC + prod[WORD_W-1:0];
            default: res = prod[WORD_W-1:0];
        endcase
    end

    // counter never steps past the last busy cycle
    assert property (@(posedge CLK) disable iff (!arstN)
        (state == BUSY) |-> (cnt <= MUL_CNT_W'(MUL_LATENCY - 2)))
        else $error("vecMultiplier: BUSY outlasted MUL_LATENCY");

endmodule

`default_nettype wire

// ==== logic/vecDivider.sv ====
`default_nettype none

module vecDivider import vecUnitPkg::*; (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              en,
    input  logic              memStall,
    input  logic [WORD_W-1:0] opA,
    input  logic [WORD_W-1:0] opB,
    input  logic              opUnsigned,
    input  logic              divRem,
    output logic              busy,
    output logic [WORD_W-1:0] res
);

    unitState_e           state;
    logic [DIV_CNT_W-1:0] cnt;
    logic [WORD_W-1:0]    remReg, quoReg, divReg, dividend;
    logic                 negQ, negR, divZero, overflow;
    logic [WORD_W-1:0]    magA, magB;
    logic [WORD_W-1:0]    stepRem, stepQuo, stepDiv;
    logic [WORD_W:0]      shifted, trial;
    logic [WORD_W-1:0]    nextRem, nextQuo;
    logic [WORD_W-1:0]    quoOut, remOut;
    logic                 start;

    assign start = en && (state == IDLE);
    assign busy  = start || (state == BUSY);

    assign magA = (!opUnsigned && opA[WORD_W-1]) ? -opA : opA;
    assign magB = (!opUnsigned && opB[WORD_W-1]) ? -opB : opB;

    // first restoring step runs in the start cycle, straight off the operands
    assign stepRem = (state == IDLE) ? '0 : remReg;
    assign stepQuo = (state == IDLE) ? magA : quoReg;
    assign stepDiv = (state == IDLE) ? magB : divReg;

    assign shifted = {stepRem, stepQuo[WORD_W-1]};
    assign trial   = shifted - {1'b0, stepDiv};
    assign nextRem = trial[WORD_W] ? shifted[WORD_W-1:0] : trial[WORD_W-1:0];
    assign nextQuo = {stepQuo[WORD_W-2:0], !trial[WORD_W]};

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state  <= IDLE;
            cnt    <= '0;
            quoReg <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (en) begin
                        quoReg <= nextQuo;
                        cnt    <= '0;
                        state  <= BUSY;
                    end
                end
                BUSY: begin
                    if (!memStall) begin
                        quoReg <= nextQuo;
                        if (cnt == DIV_CNT_W'(DIV_CYCLES - 2)) begin
                            state <= DONE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;  // DONE
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            divReg   <= magB;
            dividend <= opA;
            divZero  <= (opB == '0);
            overflow <= !opUnsigned && (opA == {1'b1, {(WORD_W-1){1'b0}}}) && (&opB);
            negQ     <= !opUnsigned && (opA[WORD_W-1] ^ opB[WORD_W-1]);
            negR     <= !opUnsigned && opA[WORD_W-1];  // rem follows dividend
        end
        if (start || (state == BUSY && !memStall)) begin
            remReg <= nextRem;
        end
    end

    always_comb begin
        if (divZero) begin
            quoOut = '1;
            remOut = dividend;
        end else if (overflow) begin
            quoOut = dividend;
            remOut = '0;
        end else begin
            quoOut = negQ ? -quoReg : quoReg;
            remOut = negR ? -remReg : remReg;
        end
    end

    assign res = divRem ? remOut : quoOut;

    assert property (@(posedge CLK) disable iff (!arstN)
        (state == BUSY) |-> (cnt < DIV_CNT_W'(DIV_CYCLES - 1)))
        else $error("vecDivider: iteration count overran DIV_CYCLES");

endmodule

`default_nettype wire

// ==== logic/vecFuncUnit.sv ====
`default_nettype none

module vecFuncUnit import vecOpPkg::*, vecUnitPkg::*; (
    input  logic              CLK,
    input  logic              arstN,
    input  logic [WORD_W-1:0] opA,  // vs2
    input  logic [WORD_W-1:0] opB,  // vs1
    input  logic [WORD_W-1:0] opC,  // accumulator
    input  logic              maskBit,
    input  vfuSel_e           vfuSel,
    input  aluOp_e            aluOp,
    input  mulOp_e            mulOp,
    input  logic              opUnsigned,
    input  logic              divRem,
    input  vsew_e             vsew,
    input  logic              memStall,
    output logic [WORD_W-1:0] vres,
    output logic              vfuStall
);

    logic [WORD_W-1:0] aluRes, mulRes, divRes;
    logic              mulEn, divEn;
    logic              mulBusy, divBusy;

    assign mulEn = (vfuSel == MUL);
    assign divEn = (vfuSel == DIV);

    vecAlu alu0 (
        .opA, .opB, .maskBit, .opUnsigned, .aluOp, .vsew,
        .res (aluRes)
    );

    vecMultiplier mul0 (
        .CLK, .arstN, .en (mulEn), .memStall,
        .opA, .opB, .opC, .mulOp, .opUnsigned,
        .busy (mulBusy), .res (mulRes)
    );

    vecDivider div0 (
        .CLK, .arstN, .en (divEn), .memStall,
        .opA, .opB, .opUnsigned, .divRem,
        .busy (divBusy), .res (divRes)
    );

    assign vfuStall = (mulEn && mulBusy) || (divEn && divBusy);

    always_comb begin
        case (vfuSel)
            PASS_A:  vres = opA;
            PASS_B:  vres = opB;
            ALU:     vres = aluRes;
            MUL:     vres = mulRes;
            DIV:     vres = divRes;
            default: vres = '0;
        endcase
    end

    // upstream holds the operation while the unit stalls
    assert property (@(posedge CLK) disable iff (!arstN)
        vfuStall |=> $stable({vfuSel, mulOp, opA, opB, opC, opUnsigned, divRem}))
        else $error("vecFuncUnit: operation changed during a stall");

endmodule

`default_nettype wire

// ==== tb/vecFuncUnitTb.sv ====
`default_nettype none

module vecFuncUnitTb import vecOpPkg::*, vecUnitPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD      = 100;
    localparam int ALU_ROUNDS  = 8;
    localparam int MUL_ROUNDS  = 30;
    localparam int DIV_ROUNDS  = 20;
    localparam int NUM_ALU_OPS = 30;
    localparam int TOTAL_OPS   = ALU_ROUNDS * 3 * NUM_ALU_OPS + NUM_ALU_OPS * 18 + 4
                               + MUL_ROUNDS * 6 + 54 + DIV_ROUNDS * 4 + 24 + 8 + 15;

    logic              CLK        = 1'b0;
    logic              arstN      = 1'b0;
    logic [WORD_W-1:0] opA        = '0;
    logic [WORD_W-1:0] opB        = '0;
    logic [WORD_W-1:0] opC        = '0;
    logic              maskBit    = 1'b0;
    logic              opUnsigned = 1'b0;
    logic              divRem     = 1'b0;
    logic              memStall   = 1'b0;
    vfuSel_e           vfuSel     = ALU;
    aluOp_e            aluOp      = ADD;
    mulOp_e            mulOp      = MUL_LO;
    vsew_e             vsew       = SEW32;
    logic [WORD_W-1:0] vres;
    logic              vfuStall;

    logic [31:0]       rngState = 32'hdb5d_4168;
    logic [WORD_W-1:0] corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    logic [WORD_W-1:0] expVal;
    int                expStall;
    int                stallCnt;
    logic              pending = 1'b0;  // op in flight, cleared by the compare process
    string             testName;

    vecFuncUnit dut0 (
        .CLK, .arstN, .opA, .opB, .opC, .maskBit, .vfuSel, .aluOp, .mulOp,
        .opUnsigned, .divRem, .vsew, .memStall, .vres, .vfuStall
    );

    initial begin
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic [WORD_W-1:0] pickOperand();
        logic [31:0] r;
        r = nextRandom();
        if (r[2:0] == 3'd0) return corners[r[4:3] % 3];  // corner value now and then
        return nextRandom();
    endfunction

    function automatic logic [WORD_W-1:0] expectedResult(
        vfuSel_e sel, aluOp_e aop, mulOp_e mop, logic [WORD_W-1:0] a,
        logic [WORD_W-1:0] b, logic [WORD_W-1:0] c, logic m, logic uns, logic rem, vsew_e sew
    );
        logic [WORD_W:0] carrySum;
        logic [4:0]      sh;
        logic            lt;
        logic            eq;
        longint          pa;
        longint          pb;
        logic [63:0]     prod;
        int              sa;
        int              sb;
        carrySum = 33'(a) + 33'(b) + 33'(aop == MADC && m);
        sh = (sew == SEW8) ? 5'(b & 32'h7) : (sew == SEW16) ? 5'(b & 32'hf) : b[4:0];
        eq = (a == b);
        lt = uns ? (a < b) : (int'(a) < int'(b));
        pa = uns ? longint'({32'b0, a}) : longint'(int'(a));
        pb = uns ? longint'({32'b0, b}) : longint'(int'(b));
        prod = pa * pb;
        case (sel)
            PASS_A: return a;
            PASS_B: return b;
            MUL: begin
                if (mop == MUL_HI) return prod[63:32];
                if (mop == MACC) return c + prod[31:0];
                return prod[31:0];
            end
            DIV: begin
                if (b == '0) return rem ? a : '1;
                if (!uns && a == 32'h8000_0000 && b == '1) return rem ? '0 : a;
                if (uns) return rem ? a % b : a / b;
                sa = a;
                sb = b;
                return rem ? WORD_W'(sa % sb) : WORD_W'(sa / sb);
            end
            default: begin
                case (aop)
                    ADD:           return a + b;
                    SUB:           return a - b;
                    RSB:           return b - a;
                    EXT:           return a;
                    ADC:           return a + b + WORD_W'(m);
                    SBC:           return a - b - WORD_W'(m);
                    MADC_NC, MADC: return WORD_W'(carrySum[WORD_W]);
                    MSBC_NB, MSBC: return WORD_W'(33'(a) < 33'(b) + 33'(aop == MSBC && m));
                    AND:           return a & b;
                    NAND:          return ~(a & b);
                    ANDN:          return a & ~b;
                    OR:            return a | b;
                    NOR:           return ~(a | b);
                    ORN:           return a | ~b;
                    XOR:           return a ^ b;
                    XNOR:          return ~(a ^ b);
                    SRL:           return a >> sh;
                    SRA:           return WORD_W'($signed(a) >>> sh);
                    SLL:           return a << sh;
                    SEQ:           return WORD_W'(eq);
                    SNE:           return WORD_W'(!eq);
                    SLT:           return WORD_W'(lt);
                    SLE:           return WORD_W'(lt || eq);
                    SGT:           return WORD_W'(!lt && !eq);
                    MIN:           return lt ? a : b;
                    MAX:           return lt ? b : a;
                    MERGE:         return m ? b : a;
                    default:       return b;  // MOVE
                endcase
            end
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // counts stall cycles, checks the result once the stall drops
    always @(negedge CLK) begin
        if (pending) begin
            if (vfuStall) begin
                stallCnt++;
            end else begin
                checkValue(testName, expVal, vres);
                checkValue({testName, " stall length"}, WORD_W'(expStall), WORD_W'(stallCnt));
                pending = 1'b0;
            end
        end
    end

    task automatic launch(input string name, input int memCycles);
        expVal   = expectedResult(vfuSel, aluOp, mulOp, opA, opB, opC, maskBit, opUnsigned,
                                  divRem, vsew);
        expStall = memCycles + ((vfuSel == MUL) ? MUL_LATENCY : (vfuSel == DIV) ? DIV_CYCLES : 0);
        testName = name;
        stallCnt = 0;
        pending  = 1'b1;
        if (memCycles > 0) begin
            @(posedge CLK);  // unit is in BUSY from here
            #5 memStall = 1'b1;
            repeat (memCycles) @(posedge CLK);
            #5 memStall = 1'b0;
        end
        wait (!pending);
    endtask

    task automatic singleCycleOp(input vfuSel_e sel, input aluOp_e op,
                                 input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                                 input logic m, input logic uns, input vsew_e sew);
        @(posedge CLK);
        #5;
        vfuSel     = sel;
        aluOp      = op;
        opA        = a;
        opB        = b;
        maskBit    = m;
        opUnsigned = uns;
        vsew       = sew;
        launch($sformatf("%s %s sew%0d", sel.name(), op.name(), sew), 0);
    endtask

    task automatic multiply(input mulOp_e op, input logic [WORD_W-1:0] a,
                            input logic [WORD_W-1:0] b, input logic [WORD_W-1:0] c,
                            input logic uns, input int memCycles);
        @(posedge CLK);
        #5;
        vfuSel     = MUL;
        mulOp      = op;
        opA        = a;
        opB        = b;
        opC        = c;
        opUnsigned = uns;
        launch($sformatf("%s uns%0b a=%h b=%h", op.name(), uns, a, b), memCycles);
    endtask

    task automatic divide(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                          input logic uns, input logic rem, input int memCycles);
        @(posedge CLK);
        #5;
        vfuSel     = DIV;
        opA        = a;
        opB        = b;
        opUnsigned = uns;
        divRem     = rem;
        launch($sformatf("%s uns%0b a=%h b=%h", rem ? "REM" : "DIV", uns, a, b), memCycles);
    endtask

    initial begin
        logic [31:0] r;
        repeat (10) @(posedge CLK);
        #5 arstN = 1'b1;

        for (int i = 0; i < ALU_ROUNDS; i++) begin
            for (int s = 0; s < 3; s++) begin
                for (int op = 0; op < NUM_ALU_OPS; op++) begin
                    r = nextRandom();
                    singleCycleOp(ALU, aluOp_e'(op), pickOperand(), pickOperand(),
                                  r[0], r[1], vsew_e'(s));
                end
            end
        end
        for (int op = 0; op < NUM_ALU_OPS; op++) begin
            for (int c = 0; c < 18; c++) begin  // all corner pairs, signed and unsigned
                singleCycleOp(ALU, aluOp_e'(op), corners[c % 3], corners[(c / 3) % 3],
                              1'(c), 1'(c / 9), SEW32);
            end
        end
        for (int i = 0; i < 2; i++) begin
            singleCycleOp(PASS_A, ADD, nextRandom(), nextRandom(), 1'b0, 1'b0, SEW32);
            singleCycleOp(PASS_B, ADD, nextRandom(), nextRandom(), 1'b0, 1'b0, SEW32);
        end

        for (int i = 0; i < MUL_ROUNDS; i++) begin
            for (int c = 0; c < 6; c++) begin
                multiply(mulOp_e'(c % 3), pickOperand(), pickOperand(), nextRandom(),
                         1'(c / 3), 0);
            end
        end
        for (int c = 0; c < 54; c++) begin
            multiply(mulOp_e'(c % 3), corners[(c / 3) % 3], corners[(c / 9) % 3],
                     nextRandom(), 1'(c / 27), 0);
        end

        for (int i = 0; i < DIV_ROUNDS; i++) begin
            for (int c = 0; c < 4; c++) begin
                divide(pickOperand(), pickOperand() >> (i % 24), 1'(c), 1'(c / 2), 0);
            end
        end
        for (int c = 0; c < 24; c++) begin  // divide by zero and signed overflow
            divide(corners[c % 3], ((c / 3) % 2 == 1) ? '1 : '0, 1'(c / 6), 1'(c / 12), 0);
        end

        for (int k = 1; k <= 4; k++) begin
            multiply(MACC, nextRandom(), nextRandom(), nextRandom(), 1'b0, k);
            divide(nextRandom(), nextRandom() >> 8, 1'b0, 1'(k), k);
        end

        for (int i = 0; i < 5; i++) begin  // no idle cycle between ops
            multiply(MUL_HI, nextRandom(), nextRandom(), '0, 1'(i), 0);
            divide(nextRandom(), nextRandom() >> 4, 1'(i), 1'(i / 2), 0);
            singleCycleOp(ALU, ADD, nextRandom(), nextRandom(), 1'b0, 1'b0, SEW32);
        end

        @(posedge CLK);
        $display("Test passed");
        $finish;
    end

    initial begin
        #(longint'(TOTAL_OPS) * (DIV_CYCLES + 8) * PERIOD + 20 * PERIOD);
        $display("Timeout: the operations did not complete in the allowed time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/vecOpPkg.sv
logic/vecUnitPkg.sv
logic/vecAlu.sv
logic/vecMultiplier.sv
logic/vecDivider.sv
logic/vecFuncUnit.sv
tb/vecFuncUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vecFuncUnitTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
